// File: logic/mem_mgr_pkg.sv
// widths, channel count and shared structs of the data-cache memory manager

package mem_mgr_pkg;

    //**********************************************************************
    // widths
    //**********************************************************************
    localparam int ADDR_BITS = 32;      // memory byte address
    localparam int LINE_BITS = 512;     // one 64 byte cache line
    localparam int NUM_CHAN  = 4;       // fill output channels
    localparam int ID_BITS   = 8;       // request id inside a tag

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [LINE_BITS-1:0] line_t;

    //**********************************************************************
    // request and response records
    //**********************************************************************

    // travels with a read from issue to return
    typedef struct packed {
        logic [NUM_CHAN-1:0] rotate;    // one-hot output channel
        logic [ID_BITS-1:0]  req_id;
    } tag_t;

    // head of the request queue
    typedef struct packed {
        addr_t addr;                    // line address, not rebased
        tag_t  tag;
    } mem_req_t;

    // returned line going to an output channel
    typedef struct packed {
        tag_t  tag;
        line_t line;
    } fill_pkt_t;

    // heads of the victim address and data queues
    typedef struct packed {
        addr_t addr;
        line_t line;
    } victim_t;

endpackage

// File: logic/fill_issue.sv
// fill request FSM driving the memory read address channel
`timescale 1ns/1ns

module fill_issue
    import mem_mgr_pkg::*;
#(
    parameter addr_t MEM_BASE_ADDR = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  mem_req_t            req,        // request queue head
    input  logic                req_empty,
    input  logic [NUM_CHAN-1:0] fill_full,
    input  logic                tag_full,
    input  logic                ar_ready,
    output logic                ar_valid,
    output addr_t               ar_addr,
    output logic                req_pop,
    output logic                tag_push,
    output tag_t                tag_in
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr_wait,
        st_pop,
        st_done
    } state_t;

    state_t state;
    state_t state_next;
    addr_t  addr_q;                 // rebased address held for ar
    tag_t   tag_q;
    logic   chan_free;
    logic   start;

    // destination channel must have room before the read goes out
    assign chan_free = ~|(req.tag.rotate & fill_full);
    assign start     = !req_empty && chan_free && !tag_full;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_addr_wait;
                end
            end
            st_addr_wait: begin
                if (ar_ready) begin     // ar transfer this cycle
                    state_next = st_pop;
                end
            end
            st_pop:  state_next = st_done;
            st_done: state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // capture request payload when leaving idle
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            addr_q <= MEM_BASE_ADDR + req.addr;
            tag_q  <= req.tag;
        end
    end

    assign ar_valid = (state == st_addr_wait);
    assign ar_addr  = addr_q;
    assign req_pop  = (state == st_pop);    // head leaves with its tag
    assign tag_push = (state == st_pop);
    assign tag_in   = tag_q;

endmodule

// File: logic/fill_return.sv
// in-order tag queue and steering of read beats to the fill channels
`timescale 1ns/1ns

module fill_return
    import mem_mgr_pkg::*;
#(
    parameter int TAG_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                tag_push,
    input  tag_t                tag_in,
    input  logic                r_valid,
    input  line_t               r_data,
    input  logic [NUM_CHAN-1:0] fill_full,
    output logic                tag_full,
    output logic                r_ready,
    output fill_pkt_t           fill,
    output logic [NUM_CHAN-1:0] fill_push
);

    localparam int PTR_BITS = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(TAG_DEPTH + 1);

    tag_t                tag_mem [TAG_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;     // outstanding reads
    tag_t                head;
    logic                tag_empty;
    logic                push_ok;
    logic                fire;

    // circular advance, depth need not be a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(TAG_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign tag_full  = (count == CNT_BITS'(TAG_DEPTH));
    assign tag_empty = (count == '0);
    assign push_ok   = tag_push && !tag_full;
    assign head      = tag_mem[rd_ptr];

    // hold off beats on any full channel, or until the tag has landed
    assign r_ready = !(|fill_full) && !tag_empty;
    assign fire    = r_valid && r_ready;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            tag_mem[wr_ptr] <= tag_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (fire) begin     // pop only on an accepted beat
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push_ok && !fire) begin
                count <= count + 1'b1;
            end else if (fire && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    //**********************************************************************
    // beat to channel
    //**********************************************************************
    assign fill.tag  = head;
    assign fill.line = r_data;
    assign fill_push = fire ? head.rotate : '0;    // oldest tag picks the channel

endmodule

// File: logic/victim_writeback.sv
// victim line writeback FSM over the memory write channels
`timescale 1ns/1ns

module victim_writeback
    import mem_mgr_pkg::*;
#(
    parameter addr_t MEM_BASE_ADDR = 32'h0000_0000
) (
    input  logic    clk,
    input  logic    rst,
    input  victim_t victim,             // heads of both victim queues
    input  logic    victim_addr_empty,
    input  logic    victim_data_empty,
    input  logic    clear_full,
    input  logic    aw_ready,
    input  logic    w_ready,
    input  logic    b_valid,
    output logic    aw_valid,
    output addr_t   aw_addr,
    output logic    w_valid,
    output line_t   w_data,
    output logic    b_ready,
    output logic    victim_pop,
    output addr_t   clear_addr,
    output logic    clear_push
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,        // aw_valid up
        st_data,        // w_valid up
        st_resp,        // waiting on b
        st_retire,      // pop victim, push clear
        st_done
    } state_t;

    state_t state;
    state_t state_next;
    addr_t  base_addr_q;    // rebased address for aw
    addr_t  addr_q;         // unbased address for the clear queue
    line_t  line_q;
    logic   start;

    // clear queue must have room for the retire push
    assign start = !victim_addr_empty && !victim_data_empty && !clear_full;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_addr;
                end
            end
            st_addr: begin
                if (aw_ready) begin
                    state_next = st_data;
                end
            end
            st_data: begin
                if (w_ready) begin
                    state_next = st_resp;
                end
            end
            st_resp: begin
                if (b_valid) begin  // write acknowledged
                    state_next = st_retire;
                end
            end
            st_retire: state_next = st_done;
            st_done:   state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            base_addr_q <= MEM_BASE_ADDR + victim.addr;
            addr_q      <= victim.addr;
            line_q      <= victim.line;
        end
    end

    assign aw_valid   = (state == st_addr);
    assign aw_addr    = base_addr_q;
    assign w_valid    = (state == st_data);
    assign w_data     = line_q;
    assign b_ready    = (state == st_resp);
    assign victim_pop = (state == st_retire);  // both victim queues together
    assign clear_push = (state == st_retire);
    assign clear_addr = addr_q;

endmodule

// File: logic/dcache_mem_manager.sv
// top level of the data-cache memory manager, fill and writeback paths
`timescale 1ns/1ns

module dcache_mem_manager
    import mem_mgr_pkg::*;
#(
    parameter addr_t MEM_BASE_ADDR = 32'h0000_0000,
    parameter int    TAG_DEPTH     = 8
) (
    input  logic                clk,
    input  logic                rst,
    // request queue
    input  mem_req_t            req,
    input  logic                req_empty,
    output logic                req_pop,
    // fill output channels
    output fill_pkt_t           fill,
    output logic [NUM_CHAN-1:0] fill_push,
    input  logic [NUM_CHAN-1:0] fill_full,
    // victim queues
    input  victim_t             victim,
    input  logic                victim_addr_empty,
    input  logic                victim_data_empty,
    output logic                victim_pop,
    // clear queue
    output addr_t               clear_addr,
    output logic                clear_push,
    input  logic                clear_full,
    // memory read
    output logic                ar_valid,
    output addr_t               ar_addr,
    input  logic                ar_ready,
    input  logic                r_valid,
    input  line_t               r_data,
    output logic                r_ready,
    // memory write
    output logic                aw_valid,
    output addr_t               aw_addr,
    input  logic                aw_ready,
    output logic                w_valid,
    output line_t               w_data,
    input  logic                w_ready,
    input  logic                b_valid,
    output logic                b_ready
);

    logic tag_full;
    logic tag_push;
    tag_t tag_in;

    //**********************************************************************
    // fill path
    //**********************************************************************
    fill_issue #(
        .MEM_BASE_ADDR (MEM_BASE_ADDR)
    ) u_fill_issue (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_empty (req_empty),
        .fill_full (fill_full),
        .tag_full  (tag_full),
        .ar_ready  (ar_ready),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .req_pop   (req_pop),
        .tag_push  (tag_push),
        .tag_in    (tag_in)
    );

    fill_return #(
        .TAG_DEPTH (TAG_DEPTH)
    ) u_fill_return (
        .clk       (clk),
        .rst       (rst),
        .tag_push  (tag_push),
        .tag_in    (tag_in),
        .r_valid   (r_valid),
        .r_data    (r_data),
        .fill_full (fill_full),
        .tag_full  (tag_full),
        .r_ready   (r_ready),
        .fill      (fill),
        .fill_push (fill_push)
    );

    //**********************************************************************
    // writeback path
    //**********************************************************************
    victim_writeback #(
        .MEM_BASE_ADDR (MEM_BASE_ADDR)
    ) u_victim_writeback (
        .clk               (clk),
        .rst               (rst),
        .victim            (victim),
        .victim_addr_empty (victim_addr_empty),
        .victim_data_empty (victim_data_empty),
        .clear_full        (clear_full),
        .aw_ready          (aw_ready),
        .w_ready           (w_ready),
        .b_valid           (b_valid),
        .aw_valid          (aw_valid),
        .aw_addr           (aw_addr),
        .w_valid           (w_valid),
        .w_data            (w_data),
        .b_ready           (b_ready),
        .victim_pop        (victim_pop),
        .clear_addr        (clear_addr),
        .clear_push        (clear_push)
    );

endmodule

// File: verif/dcache_mem_manager_props.sv
// handshake hold, fill one-hot and retire pairing assertions, bound to the top level
`timescale 1ns/1ns

module dcache_mem_manager_props
    import mem_mgr_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                ar_valid,
    input logic                ar_ready,
    input addr_t               ar_addr,
    input logic                aw_valid,
    input logic                aw_ready,
    input addr_t               aw_addr,
    input logic                w_valid,
    input logic                w_ready,
    input line_t               w_data,
    input logic                b_valid,
    input logic                b_ready,
    input logic [NUM_CHAN-1:0] fill_push,
    input logic                victim_pop,
    input logic                clear_push
);

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_valid dropped or ar_addr moved before ar_ready");

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("aw_valid dropped or aw_addr moved before aw_ready");

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w_data))
        else $error("w_valid dropped or w_data moved before w_ready");

    // one channel per beat at most
    a_fill_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(fill_push))
        else $error("fill_push drives more than one channel");

    // both retire pulses exactly one cycle after the write response
    a_retire_pair: assert property (@(posedge clk) disable iff (rst)
        {victim_pop, clear_push} == {2{$past(b_valid && b_ready)}})
        else $error("victim_pop or clear_push not one cycle after the write response");

endmodule

bind dcache_mem_manager dcache_mem_manager_props u_props (.*);

// File: verif/tb_dcache_mem_manager.sv
// testbench for the memory manager: stimulus table, queue and memory models, checks
`timescale 1ns/1ns

module tb_dcache_mem_manager
    import mem_mgr_pkg::*;
();

    localparam addr_t MEM_BASE       = 32'h1000_0000;
    localparam int    NUM_TESTS      = 12;
    localparam int    RST_CYCLES     = 3;
    localparam int    TIMEOUT_CYCLES = 60 * NUM_TESTS + 100;
    localparam line_t LINE_XOR       = {16{32'h5a3c_96e1}};

    typedef struct packed {
        logic                is_wb;         // writeback entry, else fill
        addr_t               addr;          // unbased
        logic [NUM_CHAN-1:0] rotate;
        logic [NUM_CHAN-1:0] full_mask;     // bit 0 is clear_full for a writeback
        logic [3:0]          full_cycles;
        logic [3:0]          resp_delay;    // r or b latency in cycles
    } stim_t;

    logic                clk = 1'b0;
    logic                rst;
    mem_req_t            req;
    logic                req_empty;
    logic                req_pop;
    fill_pkt_t           fill;
    logic [NUM_CHAN-1:0] fill_push;
    logic [NUM_CHAN-1:0] fill_full;
    victim_t             victim;
    logic                victim_addr_empty;
    logic                victim_data_empty;
    logic                victim_pop;
    addr_t               clear_addr;
    logic                clear_push;
    logic                clear_full;
    logic                ar_valid;
    addr_t               ar_addr;
    logic                ar_ready;
    logic                r_valid;
    line_t               r_data;
    logic                r_ready;
    logic                aw_valid;
    addr_t               aw_addr;
    logic                aw_ready;
    logic                w_valid;
    line_t               w_data;
    logic                w_ready;
    logic                b_valid;
    logic                b_ready;

    stim_t               stim_tab [NUM_TESTS];
    mem_req_t            req_q[$];          // modeled request queue
    victim_t             victim_q[$];       // both victim queues, kept in step
    addr_t               exp_ar_q[$];
    int                  exp_delay_q[$];
    fill_pkt_t           exp_fill_q[$];
    victim_t             exp_wb_q[$];
    int                  wb_delay_q[$];
    addr_t               rd_addr_q[$];      // accepted reads, oldest first
    int                  rd_due_q[$];
    logic [31:0]         lcg_state = 32'hfd5b278e;
    int                  cycle_cnt = 0;
    int                  feed_idx  = 0;
    int                  full_hold = 0;
    int                  pop_count = 0;
    int                  ar_wait   = 0;
    int                  aw_wait   = 0;
    int                  w_wait    = 0;
    int                  b_due     = 0;
    logic                b_pend    = 1'b0;
    logic                b_done    = 1'b0;  // b transfer seen on the last edge
    logic                ar_done   = 1'b0;  // ar transfer seen on the last edge
    logic                ar_valid_d      = 1'b0;
    logic                aw_valid_d      = 1'b0;
    logic                prev_clear_full = 1'b0;
    logic [NUM_CHAN-1:0] prev_rotate     = '0;
    logic [NUM_CHAN-1:0] prev_full       = '0;

    dcache_mem_manager #(
        .MEM_BASE_ADDR (MEM_BASE),
        .TAG_DEPTH     (8)
    ) dut (.*);

    always #2 clk = ~clk;

    //**********************************************************************
    // random source and line helpers
    //**********************************************************************
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_delay();
        return int'(next_rand() >> 30);     // 0 to 3 cycles
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int i = 0; i < LINE_BITS / 32; i++) begin
            l[i*32 +: 32] = next_rand();
        end
        return l;
    endfunction

    // read data rule of the memory model
    function automatic line_t mem_line(input addr_t a);
        return {(LINE_BITS / ADDR_BITS){a}} ^ LINE_XOR;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    //**********************************************************************
    // compare tasks
    //**********************************************************************
    task automatic check_fill(input fill_pkt_t got, input fill_pkt_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s tag %h line %h, expected tag %h line %h",
                $time, what, got.tag, got.line[31:0], exp.tag, exp.line[31:0]));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s low word %h, expected %h",
                $time, what, got[31:0], exp[31:0]));
        end
    endtask

    task automatic check_chan(input logic [NUM_CHAN-1:0] got, input logic [NUM_CHAN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    //**********************************************************************
    // bus models, sampled on the edge and driven 1 ns later
    //**********************************************************************
    task automatic sample_outputs();
        fill_pkt_t exp_f;
        // a start is decided on the previous cycle's inputs
        if (ar_valid && !ar_valid_d && (prev_rotate & prev_full) != '0) begin
            report_failure("a read was issued for a channel that was full");
        end
        if (aw_valid && !aw_valid_d && prev_clear_full) begin
            report_failure("a writeback started while the clear queue was full");
        end
        if (fill_full != '0) begin
            check_bit(r_ready, 1'b0, "r_ready with a full channel");
        end
        // request pop comes exactly one cycle after the ar transfer
        check_bit(req_pop, ar_done, "req_pop after the ar transfer");
        if (req_pop) begin
            void'(req_q.pop_front());
            pop_count++;
        end
        ar_done = ar_valid && ar_ready;
        if (ar_valid && ar_ready) begin
            check_addr(ar_addr, exp_ar_q.pop_front(), "ar_addr");
            rd_addr_q.push_back(ar_addr - MEM_BASE);
            rd_due_q.push_back(cycle_cnt + exp_delay_q.pop_front());
            ar_wait = rand_delay();
        end
        if (r_valid && r_ready) begin
            exp_f = exp_fill_q.pop_front();
            check_chan(fill_push, exp_f.tag.rotate, "fill_push");
            check_fill(fill, exp_f, "fill");
            void'(rd_addr_q.pop_front());
            void'(rd_due_q.pop_front());
        end else begin
            check_chan(fill_push, '0, "fill_push without an accepted beat");
        end
        if (aw_valid && aw_ready) begin
            check_addr(aw_addr, MEM_BASE + exp_wb_q[0].addr, "aw_addr");
            aw_wait = rand_delay();
        end
        if (w_valid && w_ready) begin
            check_line(w_data, exp_wb_q[0].line, "w_data");
            b_due  = cycle_cnt + wb_delay_q[0];
            b_pend = 1'b1;
            w_wait = rand_delay();
        end
        // retire comes exactly one cycle after the write response
        check_bit(victim_pop, b_done, "victim_pop after the write response");
        check_bit(clear_push, b_done, "clear_push after the write response");
        if (victim_pop) begin
            check_addr(clear_addr, exp_wb_q[0].addr, "clear_addr");
            void'(victim_q.pop_front());
            void'(exp_wb_q.pop_front());
            void'(wb_delay_q.pop_front());
            pop_count++;
        end
        b_done = b_valid && b_ready;
        if (b_valid && b_ready) begin
            b_pend = 1'b0;
        end
        ar_valid_d      = ar_valid;
        aw_valid_d      = aw_valid;
        prev_rotate     = req_empty ? '0 : req.tag.rotate;
        prev_full       = fill_full;
        prev_clear_full = clear_full;
    endtask

    task automatic load_entry(input stim_t s);
        fill_pkt_t f;
        victim_t   v;
        mem_req_t  r;
        if (s.is_wb) begin
            v.addr = s.addr;
            v.line = rand_line();
            victim_q.push_back(v);
            exp_wb_q.push_back(v);
            wb_delay_q.push_back(int'(s.resp_delay));
            clear_full = s.full_mask[0];
        end else begin
            f.tag.rotate = s.rotate;
            f.tag.req_id = ID_BITS'(feed_idx);
            f.line       = mem_line(s.addr);
            r.addr       = s.addr;
            r.tag        = f.tag;
            req_q.push_back(r);
            exp_ar_q.push_back(MEM_BASE + s.addr);
            exp_delay_q.push_back(int'(s.resp_delay));
            exp_fill_q.push_back(f);
            fill_full = s.full_mask;
        end
        full_hold = int'(s.full_cycles);
    endtask

    task automatic drive_inputs();
        rst = (cycle_cnt < RST_CYCLES);
        if (full_hold > 0) begin
            full_hold--;
        end else begin
            fill_full  = '0;
            clear_full = 1'b0;
            if (!rst && feed_idx < NUM_TESTS) begin
                load_entry(stim_tab[feed_idx]);
                feed_idx++;
            end
        end
        req_empty         = (req_q.size() == 0);
        req               = req_empty ? '0 : req_q[0];
        victim_addr_empty = (victim_q.size() == 0);
        victim_data_empty = victim_addr_empty;
        victim            = victim_addr_empty ? '0 : victim_q[0];
        ar_ready = ar_valid && (ar_wait == 0);
        aw_ready = aw_valid && (aw_wait == 0);
        w_ready  = w_valid && (w_wait == 0);
        if (ar_valid && ar_wait > 0) begin
            ar_wait--;
        end
        if (aw_valid && aw_wait > 0) begin
            aw_wait--;
        end
        if (w_valid && w_wait > 0) begin
            w_wait--;
        end
        // beats leave in address order once due
        r_valid = (rd_due_q.size() > 0) && (cycle_cnt >= rd_due_q[0]);
        r_data  = r_valid ? mem_line(rd_addr_q[0]) : '0;
        b_valid = b_pend && (cycle_cnt >= b_due);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (rst) begin
            if (cycle_cnt > 1) begin
                check_bit(ar_valid | aw_valid | w_valid | b_ready | req_pop | victim_pop
                          | clear_push | r_ready, 1'b0, "handshake output during reset");
                check_chan(fill_push, '0, "fill_push during reset");
            end
        end else begin
            sample_outputs();
        end
        #1;
        drive_inputs();
    end

    initial begin
        rst               = 1'b1;
        req               = '0;
        req_empty         = 1'b1;
        fill_full         = '0;
        victim            = '0;
        victim_addr_empty = 1'b1;
        victim_data_empty = 1'b1;
        clear_full        = 1'b0;
        ar_ready          = 1'b0;
        r_valid           = 1'b0;
        r_data            = '0;
        aw_ready          = 1'b0;
        w_ready           = 1'b0;
        b_valid           = 1'b0;
        // wb, addr, rotate, full mask, full cycles, response delay
        stim_tab = '{
            '{1'b0, 32'h0000_0040, 4'b0001, 4'b0000, 4'd0,  4'd0},
            '{1'b0, 32'h0000_0080, 4'b0010, 4'b0000, 4'd0,  4'd3},
            '{1'b0, 32'h0000_00c0, 4'b0100, 4'b0000, 4'd0,  4'd5},
            '{1'b0, 32'h0000_0100, 4'b1000, 4'b0000, 4'd0,  4'd1},
            '{1'b0, 32'h0000_1000, 4'b0100, 4'b0100, 4'd12, 4'd2},   // own channel full
            '{1'b1, 32'h0000_2000, 4'b0000, 4'b0000, 4'd0,  4'd2},
            '{1'b1, 32'h0000_2040, 4'b0000, 4'b0001, 4'd10, 4'd4},   // clear queue full
            '{1'b0, 32'h0000_3000, 4'b0001, 4'b1000, 4'd6,  4'd0},   // other channel full
            '{1'b1, 32'h0000_4000, 4'b0000, 4'b0000, 4'd0,  4'd0},
            '{1'b0, 32'h0000_5000, 4'b0010, 4'b0000, 4'd0,  4'd7},
            '{1'b1, 32'h0000_6fc0, 4'b0000, 4'b0000, 4'd0,  4'd3},
            '{1'b0, 32'h0fff_ffc0, 4'b1000, 4'b0000, 4'd0,  4'd2}
        };
        while (!(feed_idx == NUM_TESTS && req_q.size() == 0 && victim_q.size() == 0
                 && exp_fill_q.size() == 0)) begin
            @(negedge clk);
            if (cycle_cnt > TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout after %0d cycles with entries still pending",
                    cycle_cnt));
            end
        end
        repeat (4) @(negedge clk);
        if (pop_count != NUM_TESTS || exp_ar_q.size() != 0 || exp_wb_q.size() != 0) begin
            report_failure($sformatf("** Error at %0t ns: %0d pops, expected %0d",
                $time, pop_count, NUM_TESTS));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: list.f
logic/mem_mgr_pkg.sv
logic/fill_issue.sv
logic/fill_return.sv
logic/victim_writeback.sv
logic/dcache_mem_manager.sv
verif/dcache_mem_manager_props.sv
verif/tb_dcache_mem_manager.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_mem_manager
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= >>> FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q -F -- '$(FAIL_MSG)' $(LOG) || [ $$status -ne 0 ]; then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
